/* design/acc_core.sv */
`timescale 1ns/100ps
`default_nettype none

module acc_core (
  input  logic                   clk,
  input  logic                   rst_n_i,
  output logic                   instr_req_o,
  output proc_ci_pkg::mem_req_t  instr_cmd_o,
  input  logic                   instr_ack_i,
  input  proc_ci_pkg::mem_rsp_t  instr_rsp_i,
  output logic                   data_req_o,
  output proc_ci_pkg::mem_req_t  data_cmd_o,
  input  logic                   data_ack_i,
  input  proc_ci_pkg::mem_rsp_t  data_rsp_i,
  output logic                   halted_o
);

  typedef enum logic [2:0] {
    C_BOOT,
    C_FETCH,
    C_FETCH_END,
    C_EXEC,
    C_DATA,
    C_DATA_END,
    C_HALT
  } core_state_e;

  core_state_e            state_q;
  logic [7:0]             pc_q;
  logic [31:0]            acc_q;
  logic [31:0]            ir_q;
  proc_ci_pkg::core_op_e  op;

  assign op = proc_ci_pkg::core_op_e'(ir_q[31:24]);

  assign instr_req_o = (state_q == C_FETCH);
  assign data_req_o  = (state_q == C_DATA);

  always_comb begin
    instr_cmd_o.we    = 1'b0;
    instr_cmd_o.addr  = pc_q;
    instr_cmd_o.wdata = '0;
    data_cmd_o.we     = (op == proc_ci_pkg::OP_ST);
    data_cmd_o.addr   = ir_q[7:0];
    data_cmd_o.wdata  = acc_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q  <= C_BOOT;
      pc_q     <= '0;
      acc_q    <= '0;
      halted_o <= 1'b0;
    end else begin
      case (state_q)
        C_BOOT: state_q <= C_FETCH;
        C_FETCH: begin
          if (instr_ack_i) begin
            ir_q    <= instr_rsp_i.rdata;
            state_q <= C_FETCH_END;
          end
        end
        C_FETCH_END: begin
          if (!instr_ack_i) begin
            state_q <= C_EXEC;
          end
        end
        C_EXEC: begin
          case (op)
            proc_ci_pkg::OP_LDI: begin
              acc_q   <= {16'h0, ir_q[15:0]};
              pc_q    <= pc_q + 1'b1;
              state_q <= C_FETCH;
            end
            proc_ci_pkg::OP_LD, proc_ci_pkg::OP_ADD,
            proc_ci_pkg::OP_SUB, proc_ci_pkg::OP_ST: begin
              state_q <= C_DATA;
            end
            proc_ci_pkg::OP_JNZ: begin
              pc_q    <= (acc_q != '0) ? ir_q[7:0] : pc_q + 1'b1;
              state_q <= C_FETCH;
            end
            proc_ci_pkg::OP_HALT: begin
              halted_o <= 1'b1;
              state_q  <= C_HALT;
            end
            // Undefined opcode runs as a no-op
            default: begin
              pc_q    <= pc_q + 1'b1;
              state_q <= C_FETCH;
            end
          endcase
        end
        C_DATA: begin
          if (data_ack_i) begin
            case (op)
              proc_ci_pkg::OP_LD:  acc_q <= data_rsp_i.rdata;
              proc_ci_pkg::OP_ADD: acc_q <= acc_q + data_rsp_i.rdata;
              proc_ci_pkg::OP_SUB: acc_q <= acc_q - data_rsp_i.rdata;
              default:             acc_q <= acc_q;
            endcase
            pc_q    <= pc_q + 1'b1;
            state_q <= C_DATA_END;
          end
        end
        C_DATA_END: begin
          if (!data_ack_i) begin
            state_q <= C_FETCH;
          end
        end
        // Stays here until the host resets the core
        C_HALT: state_q <= C_HALT;
        default: state_q <= C_BOOT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   host_req_i,
  input  proc_ci_pkg::mem_req_t  host_cmd_i,
  output logic                   host_ack_o,
  output proc_ci_pkg::mem_rsp_t  host_rsp_o,
  input  logic                   instr_req_i,
  input  proc_ci_pkg::mem_req_t  instr_cmd_i,
  output logic                   instr_ack_o,
  output proc_ci_pkg::mem_rsp_t  instr_rsp_o,
  input  logic                   data_req_i,
  input  proc_ci_pkg::mem_req_t  data_cmd_i,
  output logic                   data_ack_o,
  output proc_ci_pkg::mem_rsp_t  data_rsp_o,
  output logic                   mem_en_o,
  output proc_ci_pkg::mem_req_t  mem_cmd_o,
  input  logic [31:0]            mem_rdata_i
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_MEM,
    ARB_ACK
  } arb_state_e;

  // Grant index 0 host, 1 data, 2 instruction
  arb_state_e             state_q;
  logic [1:0]             grant_q;
  logic [2:0]             req_vec;
  proc_ci_pkg::mem_req_t  cmd_vec [3];

  assign req_vec    = {instr_req_i, data_req_i, host_req_i};
  assign cmd_vec[0] = host_cmd_i;
  assign cmd_vec[1] = data_cmd_i;
  assign cmd_vec[2] = instr_cmd_i;

  assign mem_en_o  = (state_q == ARB_MEM);
  assign mem_cmd_o = cmd_vec[grant_q];

  assign host_ack_o  = (state_q == ARB_ACK) && (grant_q == 2'd0);
  assign data_ack_o  = (state_q == ARB_ACK) && (grant_q == 2'd1);
  assign instr_ack_o = (state_q == ARB_ACK) && (grant_q == 2'd2);

  // Read data is shared and only the acked port looks at it
  assign host_rsp_o.rdata  = mem_rdata_i;
  assign data_rsp_o.rdata  = mem_rdata_i;
  assign instr_rsp_o.rdata = mem_rdata_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ARB_IDLE;
      grant_q <= 2'd0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (req_vec[0]) begin
            grant_q <= 2'd0;
            state_q <= ARB_MEM;
          end else if (req_vec[1]) begin
            grant_q <= 2'd1;
            state_q <= ARB_MEM;
          end else if (req_vec[2]) begin
            grant_q <= 2'd2;
            state_q <= ARB_MEM;
          end
        end
        ARB_MEM: state_q <= ARB_ACK;
        ARB_ACK: begin
          // Hold ack until the requester lets go
          if (!req_vec[grant_q]) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/host_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module host_ctrl #(
  parameter logic [7:0] BOARD_ID = 8'hA5
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [7:0]             rx_byte_i,
  input  logic                   rx_valid_i,
  output logic [7:0]             tx_byte_o,
  output logic                   tx_start_o,
  input  logic                   tx_busy_i,
  output logic                   mem_req_o,
  output proc_ci_pkg::mem_req_t  mem_req_data_o,
  input  logic                   mem_ack_i,
  input  proc_ci_pkg::mem_rsp_t  mem_rsp_i,
  output logic                   core_rst_o,
  input  logic                   core_halted_i
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_ADDR,
    S_DATA,
    S_MEM,
    S_MEM_END,
    S_SEND,
    S_SEND_WAIT,
    S_RUN_RST,
    S_RUN_WAIT
  } ctrl_state_e;

  ctrl_state_e             state_q;
  proc_ci_pkg::host_cmd_e  cmd_q;
  logic [7:0]              addr_q;
  logic [31:0]             wdata_q;
  logic [1:0]              byte_cnt_q;
  logic [31:0]             reply_q;
  logic [2:0]              reply_cnt_q;

  assign mem_req_o  = (state_q == S_MEM);
  assign tx_start_o = (state_q == S_SEND) && !tx_busy_i;
  assign tx_byte_o  = reply_q[7:0];

  always_comb begin
    mem_req_data_o.we    = (cmd_q == proc_ci_pkg::CMD_WRITE);
    mem_req_data_o.addr  = addr_q;
    mem_req_data_o.wdata = wdata_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      cmd_q       <= proc_ci_pkg::CMD_ID;
      reply_cnt_q <= '0;
      core_rst_o  <= 1'b1;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (rx_valid_i) begin
            case (rx_byte_i)
              proc_ci_pkg::CMD_ID: begin
                reply_q     <= {24'h0, BOARD_ID};
                reply_cnt_q <= 3'd1;
                state_q     <= S_SEND;
              end
              proc_ci_pkg::CMD_WRITE, proc_ci_pkg::CMD_READ: begin
                cmd_q   <= proc_ci_pkg::host_cmd_e'(rx_byte_i);
                state_q <= S_ADDR;
              end
              proc_ci_pkg::CMD_RUN: begin
                core_rst_o <= 1'b1;
                state_q    <= S_RUN_RST;
              end
              // Unknown first bytes are ignored
              default: state_q <= S_IDLE;
            endcase
          end
        end
        S_ADDR: begin
          if (rx_valid_i) begin
            addr_q     <= rx_byte_i;
            byte_cnt_q <= '0;
            state_q    <= (cmd_q == proc_ci_pkg::CMD_WRITE) ? S_DATA : S_MEM;
          end
        end
        S_DATA: begin
          // Little-endian so the first byte lands in the low lane
          if (rx_valid_i) begin
            wdata_q    <= {rx_byte_i, wdata_q[31:8]};
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              state_q <= S_MEM;
            end
          end
        end
        S_MEM: begin
          if (mem_ack_i) begin
            if (cmd_q == proc_ci_pkg::CMD_WRITE) begin
              reply_q     <= {24'h0, proc_ci_pkg::REPLY_OK};
              reply_cnt_q <= 3'd1;
            end else begin
              reply_q     <= mem_rsp_i.rdata;
              reply_cnt_q <= 3'd4;
            end
            state_q <= S_MEM_END;
          end
        end
        S_MEM_END: begin
          if (!mem_ack_i) begin
            state_q <= S_SEND;
          end
        end
        S_SEND: begin
          if (!tx_busy_i) begin
            reply_q     <= {8'h00, reply_q[31:8]};
            reply_cnt_q <= reply_cnt_q - 3'd1;
            state_q     <= S_SEND_WAIT;
          end
        end
        S_SEND_WAIT: begin
          if (!tx_busy_i) begin
            state_q <= (reply_cnt_q == 3'd0) ? S_IDLE : S_SEND;
          end
        end
        S_RUN_RST: begin
          core_rst_o <= 1'b0;
          state_q    <= S_RUN_WAIT;
        end
        S_RUN_WAIT: begin
          if (core_halted_i) begin
            reply_q     <= {24'h0, proc_ci_pkg::REPLY_OK};
            reply_cnt_q <= 3'd1;
            state_q     <= S_SEND;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/proc_ci_pkg.sv */
`default_nettype none

package proc_ci_pkg;

  // Request from one requester to the shared memory
  typedef struct packed {
    logic        we;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } mem_req_t;

  // Read data valid while ack is high
  typedef struct packed {
    logic [31:0] rdata;
  } mem_rsp_t;

  // Host command bytes in ASCII
  typedef enum logic [7:0] {
    CMD_ID    = 8'h49,  // 'I'
    CMD_WRITE = 8'h57,  // 'W'
    CMD_READ  = 8'h52,  // 'R'
    CMD_RUN   = 8'h47   // 'G'
  } host_cmd_e;

  // Core opcodes in instruction bits 31:24
  typedef enum logic [7:0] {
    OP_LDI  = 8'h01,
    OP_LD   = 8'h02,
    OP_ST   = 8'h03,
    OP_ADD  = 8'h04,
    OP_SUB  = 8'h05,
    OP_JNZ  = 8'h06,
    OP_HALT = 8'h07
  } core_op_e;

  // Acknowledge byte 'K'
  localparam logic [7:0] REPLY_OK = 8'h4B;

endpackage

`default_nettype wire

/* design/processor_ci_top.sv */
`timescale 1ns/100ps
`default_nettype none

module processor_ci_top #(
  parameter int         CLKS_PER_BIT = 8,
  parameter logic [7:0] BOARD_ID     = 8'hA5
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic rx_i,
  output logic tx_o,
  output logic core_halted_o
);

  logic [7:0] rx_byte;
  logic       rx_valid;
  logic [7:0] tx_byte;
  logic       tx_start;
  logic       tx_busy;
  logic       core_rst;

  logic                   host_req;
  proc_ci_pkg::mem_req_t  host_cmd;
  logic                   host_ack;
  proc_ci_pkg::mem_rsp_t  host_rsp;
  logic                   instr_req;
  proc_ci_pkg::mem_req_t  instr_cmd;
  logic                   instr_ack;
  proc_ci_pkg::mem_rsp_t  instr_rsp;
  logic                   data_req;
  proc_ci_pkg::mem_req_t  data_cmd;
  logic                   data_ack;
  proc_ci_pkg::mem_rsp_t  data_rsp;

  logic                   mem_en;
  proc_ci_pkg::mem_req_t  mem_cmd;
  logic [31:0]            mem_rdata;

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rx_i    (rx_i),
    .byte_o  (rx_byte),
    .valid_o (rx_valid)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .start_i (tx_start),
    .byte_i  (tx_byte),
    .tx_o    (tx_o),
    .busy_o  (tx_busy)
  );

  host_ctrl #(
    .BOARD_ID (BOARD_ID)
  ) u_host_ctrl (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .rx_byte_i      (rx_byte),
    .rx_valid_i     (rx_valid),
    .tx_byte_o      (tx_byte),
    .tx_start_o     (tx_start),
    .tx_busy_i      (tx_busy),
    .mem_req_o      (host_req),
    .mem_req_data_o (host_cmd),
    .mem_ack_i      (host_ack),
    .mem_rsp_i      (host_rsp),
    .core_rst_o     (core_rst),
    .core_halted_i  (core_halted_o)
  );

  // Core runs only while the controller releases its reset
  acc_core u_acc_core (
    .clk         (clk),
    .rst_n_i     (~core_rst),
    .instr_req_o (instr_req),
    .instr_cmd_o (instr_cmd),
    .instr_ack_i (instr_ack),
    .instr_rsp_i (instr_rsp),
    .data_req_o  (data_req),
    .data_cmd_o  (data_cmd),
    .data_ack_i  (data_ack),
    .data_rsp_i  (data_rsp),
    .halted_o    (core_halted_o)
  );

  bus_arbiter u_bus_arbiter (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .host_req_i  (host_req),
    .host_cmd_i  (host_cmd),
    .host_ack_o  (host_ack),
    .host_rsp_o  (host_rsp),
    .instr_req_i (instr_req),
    .instr_cmd_i (instr_cmd),
    .instr_ack_o (instr_ack),
    .instr_rsp_o (instr_rsp),
    .data_req_i  (data_req),
    .data_cmd_i  (data_cmd),
    .data_ack_o  (data_ack),
    .data_rsp_o  (data_rsp),
    .mem_en_o    (mem_en),
    .mem_cmd_o   (mem_cmd),
    .mem_rdata_i (mem_rdata)
  );

  shared_mem u_shared_mem (
    .clk     (clk),
    .en_i    (mem_en),
    .cmd_i   (mem_cmd),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

/* design/shared_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module shared_mem (
  input  logic                   clk,
  input  logic                   en_i,
  input  proc_ci_pkg::mem_req_t  cmd_i,
  output logic [31:0]            rdata_o
);

  logic [31:0] mem_q [256];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (cmd_i.we) begin
        mem_q[cmd_i.addr] <= cmd_i.wdata;
      end
      rdata_o <= mem_q[cmd_i.addr];
    end
  end

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       rx_i,
  output logic [7:0] byte_o,
  output logic       valid_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e  state_q;
  logic [1:0] sync_q;
  logic [CNT_W-1:0] cnt_q;
  logic [2:0] bit_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q  <= 2'b11;
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_o <= 1'b0;
    end else begin
      // Two flops against metastability on the line
      sync_q  <= {sync_q[0], rx_i};
      valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!sync_q[1]) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Check the start bit again at its middle
          if (cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= sync_q[1] ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt_q  <= '0;
            byte_o <= {sync_q[1], byte_o[7:1]};
            bit_q  <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          // Framing error drops the byte
          if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            valid_o <= sync_q[1];
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  logic [7:0] byte_i,
  output logic       tx_o,
  output logic       busy_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [3:0] bit_q;
  // Data bits and stop bit still to go out
  logic [8:0] shift_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      tx_o   <= 1'b1;
      busy_o <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (!busy_o) begin
      if (start_i) begin
        tx_o    <= 1'b0;
        busy_o  <= 1'b1;
        shift_q <= {1'b1, byte_i};
        cnt_q   <= '0;
        bit_q   <= '0;
      end
    end else if (cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
      cnt_q <= '0;
      if (bit_q == 4'd9) begin
        // Stop bit time is over
        busy_o <= 1'b0;
      end else begin
        tx_o    <= shift_q[0];
        shift_q <= {1'b1, shift_q[8:1]};
        bit_q   <= bit_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_processor_ci \
  --Mdir obj_dir -o sim_tb_processor_ci
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_processor_ci)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
exit 1

/* tb/tb_processor_ci.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_processor_ci;

  localparam int          CLKS_PER_BIT = 8;
  localparam logic [7:0]  BOARD_ID     = 8'hA5;
  localparam logic [31:0] RAND_SEED    = 32'h6c9b60e9;
  localparam int          MAX_TESTS    = 40;

  // Program loop count and its data words
  localparam int         LOOP_N    = 5;
  localparam logic [7:0] ADDR_A    = 8'h40;
  localparam logic [7:0] ADDR_ONE  = 8'h41;
  localparam logic [7:0] ADDR_CNT  = 8'h42;
  localparam logic [7:0] ADDR_SUM  = 8'h43;

  // One UART frame and the longest exchange of 7 frames plus slack
  localparam int FRAME_CYCLES    = 10 * CLKS_PER_BIT;
  localparam int EXCHANGE_CYCLES = 8 * FRAME_CYCLES;
  localparam int REPLY_WAIT      = 4 * FRAME_CYCLES;
  localparam int RUN_CYCLES      = (LOOP_N * 7 + 6) * 16;
  localparam int RUN_BUDGET      = 2 * RUN_CYCLES;

  typedef enum logic [2:0] {
    T_ID,
    T_WRITE,
    T_READ,
    T_RUN,
    T_GARBAGE
  } test_kind_e;

  typedef struct packed {
    test_kind_e  kind;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_val;
  } test_entry_t;

  logic clk;
  logic rst_n_i;
  logic rx_i;
  logic tx_o;
  logic core_halted_o;

  test_entry_t tests [MAX_TESTS];
  string       test_names [MAX_TESTS];
  int          num_tests;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          cycle_cnt;
  int          timeout_limit;

  processor_ci_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .BOARD_ID     (BOARD_ID)
  ) u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .rx_i          (rx_i),
    .tx_o          (tx_o),
    .core_halted_o (core_halted_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    wait (timeout_limit != 0);
    while (cycle_cnt < timeout_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] encode_instr(proc_ci_pkg::core_op_e op, logic [15:0] imm);
    return {op, 8'h00, imm};
  endfunction

  function automatic void add_test(string name, test_kind_e kind, logic [7:0] addr,
                                   logic [31:0] data, logic [31:0] exp_val);
    tests[num_tests].kind    = kind;
    tests[num_tests].addr    = addr;
    tests[num_tests].data    = data;
    tests[num_tests].exp_val = exp_val;
    test_names[num_tests]    = name;
    num_tests++;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %08h actual %08h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic build_table();
    logic [31:0] prog [12];
    logic [31:0] words [4];
    logic [7:0]  addrs [4];
    logic [31:0] a_word;
    int          k;
    addrs = '{8'h00, 8'hFF, 8'h10, 8'h80};
    // Sum of A over LOOP_N passes with the counter kept in memory
    prog[0]  = encode_instr(proc_ci_pkg::OP_LDI, 16'(LOOP_N));
    prog[1]  = encode_instr(proc_ci_pkg::OP_ST, {8'h00, ADDR_CNT});
    prog[2]  = encode_instr(proc_ci_pkg::OP_LDI, 16'h0000);
    prog[3]  = encode_instr(proc_ci_pkg::OP_ST, {8'h00, ADDR_SUM});
    prog[4]  = encode_instr(proc_ci_pkg::OP_LD, {8'h00, ADDR_SUM});
    prog[5]  = encode_instr(proc_ci_pkg::OP_ADD, {8'h00, ADDR_A});
    prog[6]  = encode_instr(proc_ci_pkg::OP_ST, {8'h00, ADDR_SUM});
    prog[7]  = encode_instr(proc_ci_pkg::OP_LD, {8'h00, ADDR_CNT});
    prog[8]  = encode_instr(proc_ci_pkg::OP_SUB, {8'h00, ADDR_ONE});
    prog[9]  = encode_instr(proc_ci_pkg::OP_ST, {8'h00, ADDR_CNT});
    prog[10] = encode_instr(proc_ci_pkg::OP_JNZ, 16'h0004);
    prog[11] = encode_instr(proc_ci_pkg::OP_HALT, 16'h0000);

    add_test("board id", T_ID, 8'h00, 32'h0, {24'h0, BOARD_ID});
    for (k = 0; k < 4; k++) begin
      words[k] = $urandom();
      add_test($sformatf("write %02h", addrs[k]), T_WRITE, addrs[k], words[k],
               {24'h0, proc_ci_pkg::REPLY_OK});
    end
    for (k = 0; k < 4; k++) begin
      add_test($sformatf("read %02h", addrs[k]), T_READ, addrs[k], 32'h0, words[k]);
    end
    add_test("garbage byte", T_GARBAGE, 8'h00, 32'h78, 32'h0);
    add_test("read after garbage", T_READ, addrs[2], 32'h0, words[2]);
    for (k = 0; k < 12; k++) begin
      add_test($sformatf("load program word %0d", k), T_WRITE, 8'(k), prog[k],
               {24'h0, proc_ci_pkg::REPLY_OK});
    end
    a_word = $urandom();
    add_test("write input A", T_WRITE, ADDR_A, a_word, {24'h0, proc_ci_pkg::REPLY_OK});
    add_test("write constant 1", T_WRITE, ADDR_ONE, 32'h1, {24'h0, proc_ci_pkg::REPLY_OK});
    add_test("first run", T_RUN, 8'h00, 32'h0, {24'h0, proc_ci_pkg::REPLY_OK});
    add_test("first product", T_READ, ADDR_SUM, 32'h0, LOOP_N * a_word);
    a_word = $urandom();
    add_test("rewrite input A", T_WRITE, ADDR_A, a_word, {24'h0, proc_ci_pkg::REPLY_OK});
    add_test("second run", T_RUN, 8'h00, 32'h0, {24'h0, proc_ci_pkg::REPLY_OK});
    add_test("second product", T_READ, ADDR_SUM, 32'h0, LOOP_N * a_word);
  endtask

  // 8N1 frame on rx_i with the LSB first
  task automatic send_byte(input logic [7:0] b);
    int i;
    @(negedge clk);
    rx_i = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rx_i = b[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    rx_i = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic recv_byte(input int max_wait, output logic [7:0] data, output logic got);
    int   waited;
    int   i;
    logic stop_bit;
    got    = 1'b0;
    data   = 8'h00;
    waited = 0;
    @(negedge clk);
    while (tx_o !== 1'b0 && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    if (tx_o === 1'b0) begin
      // Sample every bit near its middle
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = tx_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      stop_bit = tx_o;
      got = 1'b1;
      if (stop_bit !== 1'b1) begin
        $display("Framing error: the reply byte from the DUT has no stop bit");
        err_cnt++;
      end
    end
  endtask

  // Little-endian reply of nbytes
  task automatic receive_word(input string name, input int nbytes, input int max_wait,
                              output logic [31:0] word, output logic ok);
    logic [7:0] b;
    logic       got;
    int         k;
    word = 32'h0;
    ok   = 1'b1;
    for (k = 0; k < nbytes && ok; k++) begin
      recv_byte(max_wait, b, got);
      if (got) begin
        word[8*k +: 8] = b;
      end else begin
        $display("%s: no reply byte %0d from the DUT within %0d cycles", name, k, max_wait);
        err_cnt++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic apply_test(input int idx);
    test_entry_t t;
    string       name;
    logic [31:0] word;
    logic [7:0]  b;
    logic        got;
    logic        ok;
    int          k;
    t    = tests[idx];
    name = test_names[idx];
    case (t.kind)
      T_ID: begin
        send_byte(proc_ci_pkg::CMD_ID);
        receive_word(name, 1, REPLY_WAIT, word, ok);
        if (ok) compare_value(name, t.exp_val, word);
      end
      T_WRITE: begin
        send_byte(proc_ci_pkg::CMD_WRITE);
        send_byte(t.addr);
        for (k = 0; k < 4; k++) begin
          send_byte(t.data[8*k +: 8]);
        end
        receive_word(name, 1, REPLY_WAIT, word, ok);
        if (ok) compare_value(name, t.exp_val, word);
      end
      T_READ: begin
        send_byte(proc_ci_pkg::CMD_READ);
        send_byte(t.addr);
        receive_word(name, 4, REPLY_WAIT, word, ok);
        if (ok) compare_value(name, t.exp_val, word);
      end
      T_RUN: begin
        send_byte(proc_ci_pkg::CMD_RUN);
        receive_word(name, 1, RUN_CYCLES + FRAME_CYCLES, word, ok);
        if (ok) compare_value(name, t.exp_val, word);
        compare_value({name, " halted"}, 32'h1, {31'h0, core_halted_o});
      end
      default: begin
        // A dropped byte must leave the tx line idle
        send_byte(t.data[7:0]);
        recv_byte(REPLY_WAIT, b, got);
        compare_value(name, 32'h0, {31'h0, got});
      end
    endcase
  endtask

  initial begin
    int i;
    int err_before;
    rx_i          = 1'b1;
    rst_n_i       = 1'b0;
    num_tests     = 0;
    err_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    timeout_limit = 0;
    void'($urandom(RAND_SEED));
    build_table();
    timeout_limit = num_tests * EXCHANGE_CYCLES + RUN_BUDGET + 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    repeat (4) @(negedge clk);

    for (i = 0; i < num_tests; i++) begin
      err_before = err_cnt;
      apply_test(i);
      if (err_cnt == err_before) begin
        pass_cnt++;
        $display("test %0d %s: ok", i, test_names[i]);
      end else begin
        fail_cnt++;
        $display("test %0d %s: failed", i, test_names[i]);
      end
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             num_tests, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
design/proc_ci_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/host_ctrl.sv
design/bus_arbiter.sv
design/shared_mem.sv
design/acc_core.sv
design/processor_ci_top.sv
tb/tb_processor_ci.sv
